/* design/game_ctrl.sv */
`timescale 1ns/1ps
`include "mastermind_defs.svh"

module game_ctrl (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   load_i,
    input  mastermind_pkg::peg_t   peg_i,
    output mastermind_pkg::round_t round_o,
    peg_bus_if.ctrl                bus,
    score_if.ctrl                  score
);
    import mastermind_pkg::*;

    game_state_e state;
    game_state_e state_nxt;
    slot_idx_t   slot;
    logic        slot_last;
    logic        release_evt;

    assign slot_last = (slot == slot_idx_t'(`MM_SLOTS - 1));

    // button let go while waiting in a release state
    assign release_evt = !load_i && (state == CODE_RELEASE || state == GUESS_RELEASE);

    // strobes fire on the press edge itself
    assign bus.wr_code  = (state == CODE_ENTRY) && load_i;
    assign bus.wr_guess = (state == GUESS_ENTRY) && load_i;
    assign bus.slot     = slot;
    assign bus.peg      = peg_i;
    assign score.start  = (state == SCORE_START);

    always_comb begin
        state_nxt = state;
        case (state)
            CODE_ENTRY: begin
                if (load_i) begin
                    state_nxt = CODE_RELEASE;
                end
            end
            CODE_RELEASE: begin
                if (!load_i) begin
                    state_nxt = slot_last ? GUESS_ENTRY : CODE_ENTRY;
                end
            end
            GUESS_ENTRY: begin
                if (load_i) begin
                    state_nxt = GUESS_RELEASE;
                end
            end
            GUESS_RELEASE: begin
                if (!load_i) begin
                    state_nxt = slot_last ? SCORE_START : GUESS_ENTRY;
                end
            end
            SCORE_START: begin
                state_nxt = SCORE_WAIT;
            end
            SCORE_WAIT: begin
                // buttons are ignored until the scorer answers
                if (score.valid) begin
                    state_nxt = GUESS_ENTRY;
                end
            end
            default: begin
                state_nxt = CODE_ENTRY;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state   <= CODE_ENTRY;
            slot    <= '0;
            round_o <= '0;
        end else begin
            state <= state_nxt;
            if (release_evt) begin
                slot <= slot_last ? slot_idx_t'(0) : slot + 1'b1;
            end else if (state == SCORE_WAIT && score.valid) begin
                slot <= '0;
            end
            // round moves on as the score is launched
            if (state == SCORE_START) begin
                if (round_o == round_t'(`MM_ROUNDS - 1)) begin
                    round_o <= '0;
                end else begin
                    round_o <= round_o + 1'b1;
                end
            end
        end
    end

    // the scorer only answers while the FSM is waiting for it
    a_valid_in_wait: assert property (
        @(posedge clock) disable iff (!resetn)
        score.valid |-> (state == SCORE_WAIT)
    );

endmodule

/* design/mastermind_defs.svh */
`ifndef MASTERMIND_DEFS_SVH
`define MASTERMIND_DEFS_SVH

// bits per colour peg
`define MM_PEG_W 3

// pegs in one code or guess row
`define MM_SLOTS 4

// round counter wraps after this many scores
`define MM_ROUNDS 8

// wide enough for a count of 0..MM_SLOTS
`define MM_SCORE_W 3

// segments a..g, active low
`define MM_SEG_W 7

`endif

/* design/mastermind_pkg.sv */
`include "mastermind_defs.svh"

package mastermind_pkg;

    typedef logic [`MM_PEG_W-1:0] peg_t;
    typedef peg_t [`MM_SLOTS-1:0] peg_row_t;
    typedef logic [$clog2(`MM_SLOTS)-1:0] slot_idx_t;
    typedef logic [`MM_SCORE_W-1:0] score_t;
    typedef logic [$clog2(`MM_ROUNDS)-1:0] round_t;
    typedef logic [`MM_SEG_W-1:0] seg_t;

    typedef enum logic [2:0] {
        CODE_ENTRY,
        CODE_RELEASE,
        GUESS_ENTRY,
        GUESS_RELEASE,
        SCORE_START,
        SCORE_WAIT
    } game_state_e;

    // hex digit to active-low segments, bit 6 is segment g
    function automatic seg_t seg_encode(input logic [3:0] value);
        case (value)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_1000;
            4'hA: return 7'b000_1000;
            4'hB: return 7'b000_0011;
            4'hC: return 7'b100_0110;
            4'hD: return 7'b010_0001;
            4'hE: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

endpackage

/* design/mastermind_top.sv */
`timescale 1ns/1ps

module mastermind_top (
    input  logic                   clock,
    input  logic                   resetn,
    input  mastermind_pkg::peg_t   peg_i,
    input  logic                   load_i,
    output mastermind_pkg::seg_t   hex0_o,
    output mastermind_pkg::seg_t   hex1_o,
    output mastermind_pkg::seg_t   hex2_o,
    output mastermind_pkg::seg_t   hex3_o,
    output mastermind_pkg::seg_t   hex4_o,
    output mastermind_pkg::seg_t   hex5_o,
    output logic                   score_valid_o,
    output mastermind_pkg::score_t red_o,
    output mastermind_pkg::score_t white_o,
    output mastermind_pkg::round_t round_o
);

    peg_bus_if u_peg_bus ();
    score_if   u_score ();

    game_ctrl u_game_ctrl (
        .clock   (clock),
        .resetn  (resetn),
        .load_i  (load_i),
        .peg_i   (peg_i),
        .round_o (round_o),
        .bus     (u_peg_bus),
        .score   (u_score)
    );

    peg_regs u_peg_regs (
        .clock  (clock),
        .resetn (resetn),
        .bus    (u_peg_bus),
        .score  (u_score)
    );

    peg_scorer u_peg_scorer (
        .clock  (clock),
        .resetn (resetn),
        .score  (u_score)
    );

    seg7_display u_seg7_display (
        .guess  (u_score.guess),
        .red    (u_score.red),
        .white  (u_score.white),
        .hex0_o (hex0_o),
        .hex1_o (hex1_o),
        .hex2_o (hex2_o),
        .hex3_o (hex3_o),
        .hex4_o (hex4_o),
        .hex5_o (hex5_o)
    );

    assign score_valid_o = u_score.valid;
    assign red_o         = u_score.red;
    assign white_o       = u_score.white;

endmodule

/* design/peg_bus_if.sv */
`timescale 1ns/1ps

// per-slot write port into the peg rows
interface peg_bus_if;
    import mastermind_pkg::*;

    logic      wr_code;
    logic      wr_guess;
    slot_idx_t slot;
    peg_t      peg;

    modport ctrl (output wr_code, output wr_guess, output slot, output peg);
    modport regs (input wr_code, input wr_guess, input slot, input peg);
endinterface

// scoring handshake, start pulse in and valid pulse out
interface score_if;
    import mastermind_pkg::*;

    logic     start;
    peg_row_t code;
    peg_row_t guess;
    logic     valid;
    score_t   red;
    score_t   white;

    modport ctrl (output start, input valid);
    modport regs (output code, output guess);
    modport scorer (input start, input code, input guess, output valid, output red, output white);
endinterface

/* design/peg_regs.sv */
`timescale 1ns/1ps

module peg_regs (
    input logic     clock,
    input logic     resetn,
    peg_bus_if.regs bus,
    score_if.regs   score
);
    import mastermind_pkg::*;

    peg_row_t code_row;
    peg_row_t guess_row;

    // one slot per strobe, never both rows at once
    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_row  <= '0;
            guess_row <= '0;
        end else begin
            if (bus.wr_code) begin
                code_row[bus.slot] <= bus.peg;
            end
            if (bus.wr_guess) begin
                guess_row[bus.slot] <= bus.peg;
            end
        end
    end

    assign score.code  = code_row;
    assign score.guess = guess_row;

endmodule

/* design/peg_scorer.sv */
`timescale 1ns/1ps
`include "mastermind_defs.svh"

module peg_scorer (
    input logic       clock,
    input logic       resetn,
    score_if.scorer   score
);
    import mastermind_pkg::*;

    localparam int SLOTS = `MM_SLOTS;

    peg_row_t         code_q;
    peg_row_t         guess_q;
    logic [SLOTS-1:0] red_now;
    logic [SLOTS-1:0] red_mask;
    logic [SLOTS-1:0] claimed;
    logic [SLOTS-1:0] pick;
    score_t           red_cnt_now;
    score_t           red_acc;
    score_t           white_acc;
    slot_idx_t        idx;
    logic             busy;
    logic             fin;
    logic             hit;

    // exact matches straight off the register rows
    always_comb begin
        red_cnt_now = '0;
        for (int i = 0; i < SLOTS; i++) begin
            red_now[i]  = (score.code[i] == score.guess[i]);
            red_cnt_now = red_cnt_now + score_t'(red_now[i]);
        end
    end

    // lowest free guess slot of the same colour as code slot idx
    always_comb begin
        hit  = 1'b0;
        pick = '0;
        if (!red_mask[idx]) begin
            for (int j = 0; j < SLOTS; j++) begin
                if (!hit && !claimed[j] && !red_mask[j] && guess_q[j] == code_q[idx]) begin
                    hit     = 1'b1;
                    pick[j] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (score.start) begin
            code_q   <= score.code;
            guess_q  <= score.guess;
            red_mask <= red_now;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy        <= 1'b0;
            fin         <= 1'b0;
            idx         <= '0;
            claimed     <= '0;
            red_acc     <= '0;
            white_acc   <= '0;
            score.valid <= 1'b0;
            score.red   <= '0;
            score.white <= '0;
        end else begin
            score.valid <= 1'b0;
            if (score.start) begin
                busy      <= 1'b1;
                idx       <= '0;
                claimed   <= '0;
                red_acc   <= red_cnt_now;
                white_acc <= '0;
            end else if (busy && !fin) begin
                claimed   <= claimed | pick;
                white_acc <= white_acc + score_t'(hit);
                idx       <= idx + 1'b1;
                fin       <= (idx == slot_idx_t'(SLOTS - 1));
            end else if (fin) begin
                // publish and hold until the next result
                fin         <= 1'b0;
                busy        <= 1'b0;
                score.valid <= 1'b1;
                score.red   <= red_acc;
                score.white <= white_acc;
            end
        end
    end

    a_no_start_busy: assert property (
        @(posedge clock) disable iff (!resetn)
        score.start |-> !busy
    );

endmodule

/* design/seg7_display.sv */
`timescale 1ns/1ps

module seg7_display (
    input  mastermind_pkg::peg_row_t guess,
    input  mastermind_pkg::score_t   red,
    input  mastermind_pkg::score_t   white,
    output mastermind_pkg::seg_t     hex0_o,
    output mastermind_pkg::seg_t     hex1_o,
    output mastermind_pkg::seg_t     hex2_o,
    output mastermind_pkg::seg_t     hex3_o,
    output mastermind_pkg::seg_t     hex4_o,
    output mastermind_pkg::seg_t     hex5_o
);
    import mastermind_pkg::*;

    // guess row on the low four digits
    assign hex0_o = seg_encode(4'(guess[0]));
    assign hex1_o = seg_encode(4'(guess[1]));
    assign hex2_o = seg_encode(4'(guess[2]));
    assign hex3_o = seg_encode(4'(guess[3]));

    // score on the top two
    assign hex4_o = seg_encode(4'(red));
    assign hex5_o = seg_encode(4'(white));

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the mastermind testbench with verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mastermind -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_mastermind" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src.f */
+incdir+design
design/mastermind_pkg.sv
design/peg_bus_if.sv
design/game_ctrl.sv
design/peg_regs.sv
design/peg_scorer.sv
design/seg7_display.sv
design/mastermind_top.sv
verification/tb_mastermind.sv

/* verification/tb_mastermind.sv */
`timescale 1ns/1ps
`include "mastermind_defs.svh"

module tb_mastermind;
    import mastermind_pkg::*;

    localparam int N_RANDOM = 20;
    localparam int N_ROUND_GUESSES = 9;
    // directed games, random games, round game, then the presses made during scoring
    localparam int N_PRESSES = (4 + 3 * 4) + (4 + 4 * 4) + N_RANDOM * 8
                             + (4 + N_ROUND_GUESSES * 4) + N_RANDOM + N_ROUND_GUESSES;
    localparam int N_SCORES = 3 + 4 + N_RANDOM + N_ROUND_GUESSES;
    localparam int N_RESETS = 4 + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_PRESSES * 2 + N_SCORES * 8 + N_RESETS * 6 + 10 + 500;
    localparam int SCORE_TIMEOUT = 16;

    logic     clock;
    logic     resetn;
    logic     load_i;
    peg_t     peg_i;
    seg_t     hex [6];
    logic     score_valid_o;
    score_t   red_o;
    score_t   white_o;
    round_t   round_o;

    peg_row_t    guess_model;
    round_t      exp_round;
    int          scores_played;
    logic [31:0] lcg_state = 32'h3ead;
    int          checks;
    int          value_errors;
    int          handshake_errors;

    mastermind_top u_dut (
        .clock         (clock),
        .resetn        (resetn),
        .peg_i         (peg_i),
        .load_i        (load_i),
        .hex0_o        (hex[0]),
        .hex1_o        (hex[1]),
        .hex2_o        (hex[2]),
        .hex3_o        (hex[3]),
        .hex4_o        (hex[4]),
        .hex5_o        (hex[5]),
        .score_valid_o (score_valid_o),
        .red_o         (red_o),
        .white_o       (white_o),
        .round_o       (round_o)
    );

    always #10 clock = ~clock;

    function automatic peg_row_t make_row(input peg_t p0, input peg_t p1,
                                          input peg_t p2, input peg_t p3);
        peg_row_t row;
        row[0] = p0;
        row[1] = p1;
        row[2] = p2;
        row[3] = p3;
        return row;
    endfunction

    // reference scoring, counted per colour
    function automatic score_t ref_red(input peg_row_t code, input peg_row_t guess);
        score_t n;
        n = '0;
        for (int i = 0; i < `MM_SLOTS; i++) begin
            if (code[i] == guess[i]) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    function automatic score_t ref_white(input peg_row_t code, input peg_row_t guess);
        int code_cnt;
        int guess_cnt;
        int total;
        total = 0;
        for (int c = 0; c < (1 << `MM_PEG_W); c++) begin
            code_cnt  = 0;
            guess_cnt = 0;
            for (int i = 0; i < `MM_SLOTS; i++) begin
                if (code[i] == peg_t'(c)) code_cnt++;
                if (guess[i] == peg_t'(c)) guess_cnt++;
            end
            total += (code_cnt < guess_cnt) ? code_cnt : guess_cnt;
        end
        return score_t'(total - int'(ref_red(code, guess)));
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function peg_t random_peg();
        lcg_state = lcg_next(lcg_state);
        return peg_t'(lcg_state >> 16);
    endfunction

    // mostly borrows colours from the code so scores are not all zero
    function peg_row_t random_guess(input peg_row_t code);
        peg_row_t row;
        for (int i = 0; i < `MM_SLOTS; i++) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[24]) begin
                row[i] = code[lcg_state[17:16]];
            end else begin
                row[i] = peg_t'(lcg_state >> 20);
            end
        end
        return row;
    endfunction

    task automatic check_score(input score_t got, input score_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_round(input round_t got, input round_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_digits();
        for (int i = 0; i < `MM_SLOTS; i++) begin
            check_seg(hex[i], seg_encode(4'(guess_model[i])), $sformatf("hex%0d_o", i));
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        resetn = 1'b0;
        load_i = 1'b0;
        peg_i  = '0;
        repeat (5) @(negedge clock);
        resetn        = 1'b1;
        guess_model   = '0;
        exp_round     = '0;
        scores_played = 0;
    endtask

    // one button press: held for a cycle, released for a cycle
    task automatic press(input peg_t p);
        peg_i  = p;
        load_i = 1'b1;
        @(negedge clock);
        load_i = 1'b0;
        @(negedge clock);
    endtask

    task automatic enter_code(input peg_row_t code);
        for (int i = 0; i < `MM_SLOTS; i++) begin
            press(code[i]);
            check_digits();
        end
    endtask

    task automatic play_guess(input peg_row_t guess, input score_t exp_red,
                              input score_t exp_white, input logic disturb);
        int waited;
        for (int i = 0; i < `MM_SLOTS; i++) begin
            press(guess[i]);
            guess_model[i] = guess[i];
            check_digits();
        end
        // a press while waiting on the scorer must be ignored
        if (disturb) begin
            @(negedge clock);
            press(~guess[0]);
        end
        waited = 0;
        while (score_valid_o !== 1'b1 && waited < SCORE_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (score_valid_o !== 1'b1) begin
            handshake_errors++;
            $display("no score_valid_o pulse came within %0d cycles of the last guess peg",
                     SCORE_TIMEOUT);
        end else begin
            // one round per score, counted modulo the round limit
            scores_played++;
            exp_round = round_t'(scores_played % `MM_ROUNDS);
            check_score(red_o, exp_red, "red_o");
            check_score(white_o, exp_white, "white_o");
            check_seg(hex[4], seg_encode(4'(exp_red)), "hex4_o");
            check_seg(hex[5], seg_encode(4'(exp_white)), "hex5_o");
            check_round(round_o, exp_round, "round_o");
            check_digits();
            @(negedge clock);
            check_flag(score_valid_o, 1'b0, "score_valid_o after its pulse");
            check_score(red_o, exp_red, "red_o held");
            check_score(white_o, exp_white, "white_o held");
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        for (int i = 0; i < 6; i++) begin
            check_seg(hex[i], seg_encode(4'h0), $sformatf("hex%0d_o after reset", i));
        end
        check_round(round_o, '0, "round_o after reset");
        repeat (10) begin
            check_flag(score_valid_o, 1'b0, "score_valid_o after reset");
            @(negedge clock);
        end
    endtask

    task automatic test_basic_scores();
        apply_reset();
        enter_code(make_row(3'd1, 3'd2, 3'd3, 3'd4));
        play_guess(make_row(3'd1, 3'd2, 3'd3, 3'd4), 3'd4, 3'd0, 1'b0);
        play_guess(make_row(3'd5, 3'd6, 3'd7, 3'd0), 3'd0, 3'd0, 1'b0);
        play_guess(make_row(3'd2, 3'd1, 3'd4, 3'd3), 3'd0, 3'd4, 1'b0);
    endtask

    task automatic test_duplicates();
        peg_row_t code;
        peg_row_t guess;
        code = make_row(3'd1, 3'd1, 3'd2, 3'd3);
        apply_reset();
        enter_code(code);
        play_guess(make_row(3'd1, 3'd2, 3'd1, 3'd1), 3'd1, 3'd2, 1'b0);
        guess = make_row(3'd1, 3'd1, 3'd1, 3'd1);
        play_guess(guess, ref_red(code, guess), ref_white(code, guess), 1'b0);
        guess = make_row(3'd3, 3'd2, 3'd1, 3'd1);
        play_guess(guess, ref_red(code, guess), ref_white(code, guess), 1'b0);
        guess = make_row(3'd2, 3'd3, 3'd3, 3'd1);
        play_guess(guess, ref_red(code, guess), ref_white(code, guess), 1'b1);
    endtask

    task automatic test_random();
        peg_row_t code;
        peg_row_t guess;
        for (int k = 0; k < N_RANDOM; k++) begin
            for (int i = 0; i < `MM_SLOTS; i++) begin
                code[i] = random_peg();
            end
            guess = random_guess(code);
            apply_reset();
            enter_code(code);
            play_guess(guess, ref_red(code, guess), ref_white(code, guess), (k % 5) == 0);
        end
    endtask

    task automatic test_round_wrap();
        peg_row_t code;
        peg_row_t guess;
        for (int i = 0; i < `MM_SLOTS; i++) begin
            code[i] = random_peg();
        end
        apply_reset();
        enter_code(code);
        for (int k = 0; k < N_ROUND_GUESSES; k++) begin
            guess = random_guess(code);
            play_guess(guess, ref_red(code, guess), ref_white(code, guess), k[0]);
        end
        check_round(round_o, round_t'(N_ROUND_GUESSES % `MM_ROUNDS), "round_o after wrap");
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("simulation timed out after %0d cycles, %0d value errors so far",
                 WATCHDOG_CYCLES, value_errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clock            = 1'b0;
        resetn           = 1'b0;
        load_i           = 1'b0;
        peg_i            = '0;
        guess_model      = '0;
        exp_round        = '0;
        scores_played    = 0;
        checks           = 0;
        value_errors     = 0;
        handshake_errors = 0;
        test_reset_state();
        test_basic_scores();
        test_duplicates();
        test_random();
        test_round_wrap();
        $display("%0d checks, %0d value errors, %0d handshake errors",
                 checks, value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
